/* vit_pkg.sv */
`default_nettype none

package vit_pkg;

    // trellis size for K = 3
    localparam int NUM_STATES = 4;
    localparam int STATE_W = 2;

    // generator taps, MSB is the current input bit
    localparam logic [STATE_W:0] GEN_0 = 3'o7;
    localparam logic [STATE_W:0] GEN_1 = 3'o5;

    // path and branch metrics
    typedef logic [7:0] metric_t;

    // one received hard-decision symbol
    typedef struct packed {
        logic g0;  // output of GEN_0
        logic g1;  // output of GEN_1
    } sym_t;

    // one decision bit per state, 1 = odd predecessor won
    typedef logic [NUM_STATES-1:0] surv_col_t;

    // branch metrics by label {g0, g1}
    typedef struct packed {
        metric_t m11;
        metric_t m10;
        metric_t m01;
        metric_t m00;
    } bm_vec_t;

endpackage

`default_nettype wire

/* branch_metric.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_metric
(
    input  wire vit_pkg::sym_t i_sym,
    output vit_pkg::bm_vec_t   o_bm
);

    import vit_pkg::*;

    // Hamming distance between the symbol and a label {g0, g1}
    function automatic metric_t hamming(input sym_t sym, input logic [1:0] lbl);
        metric_t d0;
        metric_t d1;
        d0 = metric_t'(sym.g0 ^ lbl[1]);
        d1 = metric_t'(sym.g1 ^ lbl[0]);
        return d0 + d1;
    endfunction

    always_comb
    begin
        o_bm.m00 = hamming(i_sym, 2'b00);
        o_bm.m01 = hamming(i_sym, 2'b01);
        o_bm.m10 = hamming(i_sym, 2'b10);
        o_bm.m11 = hamming(i_sym, 2'b11);  // 0 to 2 for each label
    end

endmodule

`default_nettype wire

/* acs_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module acs_unit
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             i_sym_valid,
    input  wire logic             i_last,
    input  wire logic             i_frame_start,
    input  wire vit_pkg::bm_vec_t i_bm,
    output vit_pkg::surv_col_t    o_col,
    output logic                  o_col_wr,
    output logic                  o_frame_end
);

    import vit_pkg::*;

    localparam metric_t METRIC_INIT = 8'd64;  // well above any 16-symbol path cost

    metric_t   pm     [NUM_STATES];
    metric_t   base   [NUM_STATES];
    metric_t   m_even [NUM_STATES];
    metric_t   m_odd  [NUM_STATES];
    metric_t   pm_nxt [NUM_STATES];
    surv_col_t dec;

    function automatic metric_t init_metric(input int s);
        return (s == 0) ? '0 : METRIC_INIT;  // encoder starts in state 0
    endfunction

    // register is {u, s1, s0} = {next state, low bit of the predecessor}
    function automatic logic [1:0] branch_label(input logic [STATE_W-1:0] ns,
                                                input logic odd);
        logic [STATE_W:0] taps;
        taps = {ns, odd};
        return {^(taps & GEN_0), ^(taps & GEN_1)};
    endfunction

    function automatic metric_t pick_bm(input bm_vec_t bm, input logic [1:0] lbl);
        case (lbl)
            2'b00:   return bm.m00;
            2'b01:   return bm.m01;
            2'b10:   return bm.m10;
            default: return bm.m11;
        endcase
    endfunction

    always_comb
    begin
        for (int s = 0; s < NUM_STATES; s++)
        begin
            base[s] = i_frame_start ? init_metric(s) : pm[s];  // a new frame may start now
        end
        for (int ns = 0; ns < NUM_STATES; ns++)
        begin
            m_even[ns] = base[(ns * 2) % NUM_STATES]
                         + pick_bm(i_bm, branch_label(STATE_W'(ns), 1'b0));
            m_odd[ns]  = base[(ns * 2) % NUM_STATES + 1]
                         + pick_bm(i_bm, branch_label(STATE_W'(ns), 1'b1));
            dec[ns]    = (m_odd[ns] < m_even[ns]);  // tie keeps the even one
            pm_nxt[ns] = dec[ns] ? m_odd[ns] : m_even[ns];
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int s = 0; s < NUM_STATES; s++)
            begin
                pm[s] <= init_metric(s);
            end
            o_col_wr    <= 1'b0;
            o_frame_end <= 1'b0;
        end
        else
        begin
            o_col_wr    <= i_sym_valid;
            o_frame_end <= i_sym_valid && i_last;
            if (i_sym_valid)
            begin
                pm <= pm_nxt;
            end
            else if (i_frame_start)
            begin
                for (int s = 0; s < NUM_STATES; s++)
                begin
                    pm[s] <= init_metric(s);
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_sym_valid)
        begin
            o_col <= dec;  // written to the trellis next cycle
        end
    end

endmodule

`default_nettype wire

/* trellis_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module trellis_mem #(
    parameter int TB_DEPTH = 16
)
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire vit_pkg::surv_col_t i_col,
    input  wire logic               i_col_wr,
    input  wire logic               i_frame_end,
    output vit_pkg::surv_col_t      o_col,
    output logic                    o_col_valid,
    output logic                    o_empty,
    output logic                    o_sym_credit
);

    import vit_pkg::*;

    localparam int CNT_W = $clog2(TB_DEPTH);

    surv_col_t        col_mem [TB_DEPTH];
    logic [CNT_W-1:0] depth;
    logic             rd_mode;  // 0 builds the trellis, 1 hands it back
    logic             last_wr;

    // last column of the frame, or no room for another
    assign last_wr = i_frame_end || (depth == CNT_W'(TB_DEPTH - 1));

    always_ff @(posedge clk)
    begin
        if (!rd_mode && i_col_wr)
        begin
            col_mem[depth] <= i_col;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            depth   <= '0;
            rd_mode <= 1'b0;
        end
        else if (!rd_mode)
        begin
            if (i_col_wr)
            begin
                if (last_wr)
                begin
                    rd_mode <= 1'b1;  // depth stays on the newest column
                end
                else
                begin
                    depth <= depth + 1'b1;
                end
            end
        end
        else
        begin
            if (depth == '0)
            begin
                rd_mode <= 1'b0;  // back to build mode, depth already 0
            end
            else
            begin
                depth <= depth - 1'b1;
            end
        end
    end

    // one column per cycle, newest first
    assign o_col        = col_mem[depth];
    assign o_col_valid  = rd_mode;
    assign o_sym_credit = rd_mode;  // each column read frees one slot
    assign o_empty      = rd_mode && (depth == '0);

endmodule

`default_nettype wire

/* traceback.sv */
`timescale 1ns/1ns
`default_nettype none

module traceback #(
    parameter int TB_DEPTH = 16
)
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire vit_pkg::surv_col_t i_col,
    input  wire logic               i_col_valid,
    input  wire logic               i_empty,
    input  wire logic               i_bit_credit,
    output logic                    o_bit,
    output logic                    o_bit_valid,
    output logic                    o_frame_done,
    output logic                    o_frame_start
);

    import vit_pkg::*;

    localparam int CNT_W  = $clog2(TB_DEPTH);
    localparam int CRED_W = CNT_W + 2;

    typedef enum logic [1:0] {
        TB_WALK,   // following survivors back
        TB_EMIT,   // releasing bits forward
        TB_FLUSH   // frame too short to carry bits
    } tb_state_e;

    tb_state_e          state;
    logic [STATE_W-1:0] cur_st;
    logic [CNT_W-1:0]   col_cnt;
    logic [CNT_W-1:0]   rd_idx;
    logic [CRED_W-1:0]  bit_credits;
    logic [TB_DEPTH-1:0] bit_buf;  // entry 0 belongs to the last column

    always_ff @(posedge clk)
    begin
        if (state == TB_WALK && i_col_valid)
        begin
            bit_buf[col_cnt] <= cur_st[STATE_W-1];  // input bit that entered this state
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state   <= TB_WALK;
            cur_st  <= '0;
            col_cnt <= '0;
            rd_idx  <= '0;
        end
        else
        begin
            case (state)
                TB_WALK:
                begin
                    if (i_col_valid)
                    begin
                        cur_st  <= {cur_st[STATE_W-2:0], i_col[cur_st]};
                        col_cnt <= col_cnt + 1'b1;
                        if (i_empty)
                        begin
                            cur_st  <= '0;  // terminated frames end in state 0
                            col_cnt <= '0;
                            rd_idx  <= col_cnt;  // oldest column
                            state   <= (col_cnt < CNT_W'(2)) ? TB_FLUSH : TB_EMIT;
                        end
                    end
                end
                TB_EMIT:
                begin
                    if (o_bit_valid)
                    begin
                        rd_idx <= rd_idx - 1'b1;
                        if (o_frame_done)
                        begin
                            state <= TB_WALK;
                        end
                    end
                end
                default:
                begin
                    state <= TB_WALK;
                end
            endcase
        end
    end

    // output credits from the sink
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            bit_credits <= '0;
        end
        else if (i_bit_credit && !o_bit_valid)
        begin
            if (bit_credits != '1)
            begin
                bit_credits <= bit_credits + 1'b1;
            end
        end
        else if (!i_bit_credit && o_bit_valid)
        begin
            bit_credits <= bit_credits - 1'b1;
        end
    end

    assign o_bit         = bit_buf[rd_idx];
    assign o_bit_valid   = (state == TB_EMIT) && (bit_credits != '0);
    assign o_frame_done  = o_bit_valid && (rd_idx == CNT_W'(2));  // entries 1 and 0 are tail
    assign o_frame_start = o_frame_done || (state == TB_FLUSH);

endmodule

`default_nettype wire

/* viterbi_top.sv */
`timescale 1ns/1ns
`default_nettype none

module viterbi_top #(
    parameter int TB_DEPTH = 16
)
(
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire vit_pkg::sym_t i_sym,
    input  wire logic          i_sym_valid,
    input  wire logic          i_last,
    output logic               o_sym_credit,
    input  wire logic          i_bit_credit,
    output logic               o_bit,
    output logic               o_bit_valid,
    output logic               o_frame_done
);

    import vit_pkg::*;

    bm_vec_t   bm;
    surv_col_t wr_col;
    surv_col_t rd_col;
    logic      col_wr;
    logic      frame_end;
    logic      col_valid;
    logic      tm_empty;
    logic      frame_start;  // clears path metrics for the next frame

    branch_metric branch_metric_i (
        .i_sym (i_sym),
        .o_bm  (bm)
    );

    acs_unit acs_i (
        .clk           (clk),
        .rst           (rst),
        .i_sym_valid   (i_sym_valid),
        .i_last        (i_last),
        .i_frame_start (frame_start),
        .i_bm          (bm),
        .o_col         (wr_col),
        .o_col_wr      (col_wr),
        .o_frame_end   (frame_end)
    );

    trellis_mem #(.TB_DEPTH(TB_DEPTH)) trellis_i (
        .clk          (clk),
        .rst          (rst),
        .i_col        (wr_col),
        .i_col_wr     (col_wr),
        .i_frame_end  (frame_end),
        .o_col        (rd_col),
        .o_col_valid  (col_valid),
        .o_empty      (tm_empty),
        .o_sym_credit (o_sym_credit)
    );

    traceback #(.TB_DEPTH(TB_DEPTH)) traceback_i (
        .clk           (clk),
        .rst           (rst),
        .i_col         (rd_col),
        .i_col_valid   (col_valid),
        .i_empty       (tm_empty),
        .i_bit_credit  (i_bit_credit),
        .o_bit         (o_bit),
        .o_bit_valid   (o_bit_valid),
        .o_frame_done  (o_frame_done),
        .o_frame_start (frame_start)
    );

endmodule

`default_nettype wire

/* viterbi_props.sv */
`timescale 1ns/1ns
`default_nettype none

module viterbi_props
(
    input wire logic clk,
    input wire logic rst,
    input wire logic i_sym_valid,
    input wire logic i_col_wr,
    input wire logic i_rd_mode,
    input wire logic i_sym_credit,
    input wire logic i_bit_credit,
    input wire logic i_bit_valid
);

    int granted;       // output credits from the sink
    int sent;          // bits handed to the sink
    int fail_cnt = 0;  // assertion failures so far

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            granted <= 0;
            sent    <= 0;
        end
        else
        begin
            granted <= granted + int'(i_bit_credit);
            sent    <= sent + int'(i_bit_valid);
        end
    end

    bit_needs_credit: assert property (@(posedge clk) disable iff (!rst)
        i_bit_valid |-> (granted > sent))
    else
    begin
        fail_cnt++;
        $error("bit sent with an empty output credit counter");
    end

    credit_not_on_write: assert property (@(posedge clk) disable iff (!rst)
        !(i_sym_credit && i_col_wr))
    else
    begin
        fail_cnt++;
        $error("symbol credit returned in a column write cycle");
    end

    no_sym_in_read: assert property (@(posedge clk) disable iff (!rst)
        i_sym_valid |-> !i_rd_mode)
    else
    begin
        fail_cnt++;
        $error("symbol arrived while the trellis was being read");
    end

endmodule

`default_nettype wire

/* viterbi_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module viterbi_tb;

    import vit_pkg::*;

    localparam int TB_DEPTH        = 16;
    localparam int NUM_FRAMES      = 6;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * 200 + 20;
    localparam logic [2:0] ENC_G0  = 3'o7;
    localparam logic [2:0] ENC_G1  = 3'o5;

    typedef struct packed {
        logic [13:0] msg;   // bit 0 goes out first
        int          len;
        logic [31:0] err;   // bit 2t+1 flips g0, bit 2t flips g1 of symbol t
        logic        hold;  // no output credit until the trellis is read out
    } frame_t;

    logic        clk;
    logic        rst;
    sym_t        i_sym;
    logic        i_sym_valid;
    logic        i_last;
    logic        i_bit_credit;
    logic        o_sym_credit;
    logic        o_bit;
    logic        o_bit_valid;
    logic        o_frame_done;

    frame_t      frames [NUM_FRAMES];
    sym_t        tx_syms [$];
    logic        exp_bits [$];
    logic        got_bits [$];
    int          src_credits;
    int          frame_pulses;
    int          done_cnt;
    int          done_at;
    int          checks;
    int          errors;
    int          tests;
    int unsigned seed;

    viterbi_top #(.TB_DEPTH(TB_DEPTH)) viterbi_i (
        .clk          (clk),
        .rst          (rst),
        .i_sym        (i_sym),
        .i_sym_valid  (i_sym_valid),
        .i_last       (i_last),
        .o_sym_credit (o_sym_credit),
        .i_bit_credit (i_bit_credit),
        .o_bit        (o_bit),
        .o_bit_valid  (o_bit_valid),
        .o_frame_done (o_frame_done)
    );

    bind viterbi_top viterbi_props props_i (
        .clk           (clk),
        .rst           (rst),
        .i_sym_valid   (i_sym_valid),
        .i_col_wr      (col_wr),
        .i_rd_mode     (trellis_i.rd_mode),
        .i_sym_credit  (o_sym_credit),
        .i_bit_credit  (i_bit_credit),
        .i_bit_valid   (o_bit_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: decoder did not finish the frames in %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // advance to the falling edge and record what the DUT shows there
    task automatic step_cycle();
        @(negedge clk);
        if (o_sym_credit)
        begin
            src_credits++;
            frame_pulses++;
            if (src_credits > TB_DEPTH)
            begin
                errors++;
                $display("more symbol credits came back than symbols were sent");
            end
        end
        if (o_bit_valid)
        begin
            got_bits.push_back(o_bit);
            if (o_frame_done)
            begin
                done_cnt++;
                done_at = got_bits.size();
            end
        end
        else if (o_frame_done)
        begin
            errors++;
            $display("o_frame_done pulsed without a valid bit");
        end
    endtask

    // rate 1/2 encoder, register {u, u-1, u-2}
    function automatic void build_frame(input frame_t f);
        logic [1:0] hist;
        logic [2:0] sr;
        logic       u;
        sym_t       s;
        tx_syms.delete();
        exp_bits.delete();
        hist = 2'b00;
        for (int t = 0; t < f.len + 2; t++)
        begin
            u = (t < f.len) ? f.msg[t] : 1'b0;  // two tail zeros
            sr = {u, hist};
            s.g0 = ^(sr & ENC_G0) ^ f.err[2 * t + 1];
            s.g1 = ^(sr & ENC_G1) ^ f.err[2 * t];
            tx_syms.push_back(s);
            if (t < f.len)
            begin
                exp_bits.push_back(u);
            end
            hist = {u, hist[1]};
        end
    endfunction

    // sink grants one credit at a time after the trellis is read out
    task automatic release_bits(input int len, input int n);
        while (frame_pulses < n)
        begin
            step_cycle();
        end
        repeat (4) step_cycle();
        check_count("bits with no output credit", got_bits.size(), 0);
        for (int b = 0; b < len; b++)
        begin
            i_bit_credit = 1'b1;
            step_cycle();
            i_bit_credit = 1'b0;
            step_cycle();
            step_cycle();
            check_count("bits after one more credit", got_bits.size(), b + 1);
        end
    endtask

    task automatic run_frame(input int idx);
        frame_t f;
        int     n;
        int     sent;
        int     granted;
        int     err_start;
        f = frames[idx];
        build_frame(f);
        n = tx_syms.size();
        sent = 0;
        granted = 0;
        err_start = errors;
        got_bits.delete();
        frame_pulses = 0;
        done_cnt = 0;
        done_at = -1;
        while (sent < n)
        begin
            step_cycle();
            i_sym_valid  = 1'b0;
            i_last       = 1'b0;
            i_bit_credit = 1'b0;
            if (!f.hold && granted < f.len)
            begin
                i_bit_credit = 1'b1;  // room for the whole frame
                granted++;
            end
            if (($urandom % 4) != 0 && src_credits > 0)
            begin
                i_sym       = tx_syms[sent];
                i_sym_valid = 1'b1;
                i_last      = (sent == n - 1);
                src_credits--;
                sent++;
            end
        end
        step_cycle();
        i_sym_valid  = 1'b0;
        i_last       = 1'b0;
        i_bit_credit = 1'b0;
        if (f.hold)
        begin
            release_bits(f.len, n);
        end
        while (done_cnt == 0)
        begin
            step_cycle();
        end
        repeat (2) step_cycle();  // a stray bit would show up here
        check_count("o_sym_credit pulses", frame_pulses, n);
        check_count("source credits", src_credits, TB_DEPTH);
        check_count("o_frame_done pulses", done_cnt, 1);
        check_count("bit count at o_frame_done", done_at, f.len);
        check_count("decoded bits", got_bits.size(), f.len);
        for (int i = 0; i < f.len && i < got_bits.size(); i++)
        begin
            check_bit($sformatf("o_bit[%0d]", i), got_bits[i], exp_bits[i]);
        end
        tests++;
        $display("frame %0d: %0d symbols, %0d bits, %0d errors",
                 idx, n, f.len, errors - err_start);
    endtask

    initial
    begin
        seed = $urandom(94);
        rst          = 1'b0;
        i_sym        = '0;
        i_sym_valid  = 1'b0;
        i_last       = 1'b0;
        i_bit_credit = 1'b0;
        checks       = 0;
        errors       = 0;
        tests        = 0;
        src_credits  = 0;
        frame_pulses = 0;
        done_cnt     = 0;
        done_at      = 0;
        frames[0] = '{14'h2d3b, 14, 32'h0000_0000, 1'b0};  // clean full frame
        frames[1] = '{14'h0013, 5, 32'h0000_0000, 1'b0};   // short frame
        frames[2] = '{14'h1a65, 14, 32'h0000_0400, 1'b0};  // one flipped bit
        frames[3] = '{14'h3c0f, 14, 32'h0800_0002, 1'b0};  // two flips far apart
        frames[4] = '{14'h0d56, 12, 32'h0000_0000, 1'b1};
        frames[5] = '{14'h3fff, 14, 32'h0001_0000, 1'b1};
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        src_credits = TB_DEPTH;  // source starts with a full trellis of credit
        step_cycle();
        check_bit("o_bit_valid", o_bit_valid, 1'b0);
        check_bit("o_sym_credit", o_sym_credit, 1'b0);
        check_bit("o_frame_done", o_frame_done, 1'b0);
        tests++;
        $display("reset: %0d errors", errors);
        for (int k = 0; k < NUM_FRAMES; k++)
        begin
            run_frame(k);
        end
        errors += viterbi_i.props_i.fail_cnt;
        $display("tests: %0d, checks: %0d, assertion failures: %0d, errors: %0d",
                 tests, checks, viterbi_i.props_i.fail_cnt, errors);
        if (errors == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
vit_pkg.sv
branch_metric.sv
acs_unit.sv
trellis_mem.sv
traceback.sv
viterbi_top.sv
viterbi_props.sv
viterbi_tb.sv

/* Makefile */
VERILATOR  := verilator
TOP        := viterbi_tb
FILELIST   := build.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing
RUN_ARGS   := +verilator+error+limit+1000
PASS_MSG   := Simulation passed

.PHONY: all lint clean

# build, run, and fail unless the pass message shows up in the output
all:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
